//--- source/udp_demux_pkg.sv
/*
 * Shared widths, vector types and frame states for the UDP frame demultiplexer.
 * Every RTL module takes what it needs through a wildcard import.
 */
package udp_demux_pkg;

    // number of frame outputs and the index width that selects one
    localparam int OUT_COUNT = 4;
    localparam int SEL_WIDTH = $clog2(OUT_COUNT);

    // payload is one byte per beat
    localparam int DATA_WIDTH = 8;

    // output index and one-bit-per-output masks
    typedef logic [SEL_WIDTH-1:0] port_sel_t;
    typedef logic [OUT_COUNT-1:0] port_mask_t;

    // payload beat
    typedef logic [DATA_WIDTH-1:0] payload_data_t;

    // kept header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_length_t;

    // a frame is active from header acceptance until its last beat transfers
    typedef enum logic {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_t;

endpackage

//--- source/frame_select_ctrl.sv
/*
 * Frame control for the UDP demultiplexer: captures select and drop on header
 * acceptance, registers the header, drives the per-output header valid mask
 * and the registered input readies, and turns accepted beats into a one-hot valid.
 */
module frame_select_ctrl
    import udp_demux_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // control levels
    input  logic        enable,
    input  logic        drop,
    input  port_sel_t   select,

    // header input
    input  logic        s_hdr_valid,
    output logic        s_hdr_ready,
    input  ip_addr_t    s_ip_source_ip,
    input  ip_addr_t    s_ip_dest_ip,
    input  udp_port_t   s_udp_source_port,
    input  udp_port_t   s_udp_dest_port,
    input  udp_length_t s_udp_length,

    // payload input handshake
    input  logic        s_payload_valid,
    input  logic        s_payload_last,
    output logic        s_payload_ready,

    // shared header output
    output port_mask_t  m_hdr_valid,
    input  port_mask_t  m_hdr_ready,
    output ip_addr_t    m_ip_source_ip,
    output ip_addr_t    m_ip_dest_ip,
    output udp_port_t   m_udp_source_port,
    output udp_port_t   m_udp_dest_port,
    output udp_length_t m_udp_length,

    // skid stage side
    input  logic        ready_early,
    output port_mask_t  beat_valid_mask
);

    frame_state_t frame_state;
    frame_state_t frame_state_next;
    port_sel_t    select_q;
    port_sel_t    select_next;
    logic         drop_q;
    logic         drop_next;
    logic         hdr_ready_q;
    logic         hdr_ready_next;
    logic         payload_ready_q;
    logic         payload_ready_next;
    port_mask_t   hdr_valid_q;
    port_mask_t   hdr_valid_next;
    logic         hdr_fire;
    logic         beat_fire;

    // registered readies, gated by enable without a register stage
    assign s_hdr_ready     = hdr_ready_q && enable;
    assign s_payload_ready = payload_ready_q && enable;
    assign m_hdr_valid     = hdr_valid_q;

    assign hdr_fire  = s_hdr_valid && s_hdr_ready && (frame_state == FRAME_IDLE);
    assign beat_fire = s_payload_valid && s_payload_ready;

    always_comb begin
        frame_state_next = frame_state;
        select_next      = select_q;
        drop_next        = drop_q;
        // a header valid bit drops once its output has taken the header
        hdr_valid_next   = hdr_valid_q & ~m_hdr_ready;

        // end of frame
        if (beat_fire && s_payload_last) begin
            frame_state_next = FRAME_IDLE;
            drop_next        = 1'b0;
        end

        // start of frame, routing is fixed here for the whole frame
        if (hdr_fire) begin
            frame_state_next = FRAME_ACTIVE;
            select_next      = select;
            drop_next        = drop;
            hdr_valid_next   = drop ? '0 : (port_mask_t'(1) << select);
        end

        // next header waits for frame end and for the header to be taken
        hdr_ready_next = (frame_state_next == FRAME_IDLE) && (hdr_valid_next == '0);

        // dropped frames drain regardless of the skid stage
        payload_ready_next = (frame_state_next == FRAME_ACTIVE) && (ready_early || drop_next);
    end

    // one-hot valid of the accepted beat for the selected output
    assign beat_valid_mask = (beat_fire && !drop_q) ? (port_mask_t'(1) << select_q) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_state     <= FRAME_IDLE;
            select_q        <= '0;
            drop_q          <= 1'b0;
            hdr_ready_q     <= 1'b0;
            payload_ready_q <= 1'b0;
            hdr_valid_q     <= '0;
        end else begin
            frame_state     <= frame_state_next;
            select_q        <= select_next;
            drop_q          <= drop_next;
            hdr_ready_q     <= hdr_ready_next;
            payload_ready_q <= payload_ready_next;
            hdr_valid_q     <= hdr_valid_next;
        end
    end

    // header fields, one copy shared by all outputs
    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            m_ip_source_ip    <= s_ip_source_ip;
            m_ip_dest_ip      <= s_ip_dest_ip;
            m_udp_source_port <= s_udp_source_port;
            m_udp_dest_port   <= s_udp_dest_port;
            m_udp_length      <= s_udp_length;
        end
    end

endmodule

//--- source/payload_skid_buffer.sv
/*
 * Registered-ready payload output stage with one holding register.
 * Takes beats tagged by a one-hot valid mask and presents them on the shared
 * output bus; ready_early tells the controller whether a beat may come next cycle.
 */
module payload_skid_buffer
    import udp_demux_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    // beats from the controller path
    input  payload_data_t in_data,
    input  logic          in_last,
    input  port_mask_t    beat_valid_mask,
    output logic          ready_early,

    // payload outputs
    output payload_data_t m_payload_data,
    output logic          m_payload_last,
    output port_mask_t    m_payload_valid,
    input  port_mask_t    m_payload_ready
);

    logic          in_ready_q;
    port_mask_t    out_valid_next;
    port_mask_t    hold_valid;
    port_mask_t    hold_valid_next;
    payload_data_t hold_data;
    logic          hold_last;
    logic          out_take;
    logic          store_in_to_out;
    logic          store_in_to_hold;
    logic          store_hold_to_out;

    // some output takes the beat this cycle
    assign out_take = |(m_payload_ready & m_payload_valid);

    // room next cycle unless the holding register would fill
    assign ready_early = out_take ||
        ((hold_valid == '0) && ((m_payload_valid == '0) || (beat_valid_mask == '0)));

    always_comb begin
        out_valid_next    = m_payload_valid;
        hold_valid_next   = hold_valid;
        store_in_to_out   = 1'b0;
        store_in_to_hold  = 1'b0;
        store_hold_to_out = 1'b0;

        if (in_ready_q) begin
            if (out_take || (m_payload_valid == '0)) begin
                // output free, load it directly
                out_valid_next  = beat_valid_mask;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                hold_valid_next  = beat_valid_mask;
                store_in_to_hold = 1'b1;
            end
        end else if (out_take) begin
            // no input this cycle, move the parked beat forward
            out_valid_next    = hold_valid;
            hold_valid_next   = '0;
            store_hold_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_valid <= '0;
            hold_valid      <= '0;
            in_ready_q      <= 1'b0;
        end else begin
            m_payload_valid <= out_valid_next;
            hold_valid      <= hold_valid_next;
            in_ready_q      <= ready_early;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_payload_data <= in_data;
            m_payload_last <= in_last;
        end else if (store_hold_to_out) begin
            m_payload_data <= hold_data;
            m_payload_last <= hold_last;
        end

        if (store_in_to_hold) begin
            hold_data <= in_data;
            hold_last <= in_last;
        end
    end

endmodule

//--- source/udp_demux.sv
/*
 * UDP frame demultiplexer top level.
 * Steers each header and payload frame to one of four outputs picked by
 * select at header acceptance, or discards the frame when drop is set.
 */
module udp_demux
    import udp_demux_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    // frame input
    input  logic          s_hdr_valid,
    output logic          s_hdr_ready,
    input  ip_addr_t      s_ip_source_ip,
    input  ip_addr_t      s_ip_dest_ip,
    input  udp_port_t     s_udp_source_port,
    input  udp_port_t     s_udp_dest_port,
    input  udp_length_t   s_udp_length,
    input  payload_data_t s_payload_data,
    input  logic          s_payload_last,
    input  logic          s_payload_valid,
    output logic          s_payload_ready,

    // frame outputs, header and payload buses shared
    output port_mask_t    m_hdr_valid,
    input  port_mask_t    m_hdr_ready,
    output ip_addr_t      m_ip_source_ip,
    output ip_addr_t      m_ip_dest_ip,
    output udp_port_t     m_udp_source_port,
    output udp_port_t     m_udp_dest_port,
    output udp_length_t   m_udp_length,
    output payload_data_t m_payload_data,
    output logic          m_payload_last,
    output port_mask_t    m_payload_valid,
    input  port_mask_t    m_payload_ready,

    // control
    input  logic          enable,
    input  logic          drop,
    input  port_sel_t     select
);

    port_mask_t beat_valid_mask;
    logic       ready_early;

    frame_select_ctrl ctrl (
        .clk               (clk),
        .rst               (rst),
        .enable            (enable),
        .drop              (drop),
        .select            (select),
        .s_hdr_valid       (s_hdr_valid),
        .s_hdr_ready       (s_hdr_ready),
        .s_ip_source_ip    (s_ip_source_ip),
        .s_ip_dest_ip      (s_ip_dest_ip),
        .s_udp_source_port (s_udp_source_port),
        .s_udp_dest_port   (s_udp_dest_port),
        .s_udp_length      (s_udp_length),
        .s_payload_valid   (s_payload_valid),
        .s_payload_last    (s_payload_last),
        .s_payload_ready   (s_payload_ready),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .m_udp_source_port (m_udp_source_port),
        .m_udp_dest_port   (m_udp_dest_port),
        .m_udp_length      (m_udp_length),
        .ready_early       (ready_early),
        .beat_valid_mask   (beat_valid_mask)
    );

    // data and last bypass the controller
    payload_skid_buffer skid (
        .clk             (clk),
        .rst             (rst),
        .in_data         (s_payload_data),
        .in_last         (s_payload_last),
        .beat_valid_mask (beat_valid_mask),
        .ready_early     (ready_early),
        .m_payload_data  (m_payload_data),
        .m_payload_last  (m_payload_last),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready)
    );

endmodule

//--- dv/udp_demux_assertions.sv
/*
 * Concurrent handshake checks for the UDP demultiplexer, bound into udp_demux.
 */
module udp_demux_assertions
    import udp_demux_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input logic          s_hdr_ready,
    input logic          s_payload_ready,
    input port_mask_t    m_hdr_valid,
    input port_mask_t    m_hdr_ready,
    input payload_data_t m_payload_data,
    input logic          m_payload_last,
    input port_mask_t    m_payload_valid,
    input port_mask_t    m_payload_ready
);

    // all readies and valids low right after a reset cycle
    reset_quiet: assert property (@(posedge clk)
        rst |=> (!s_hdr_ready && !s_payload_ready && m_hdr_valid == '0 && m_payload_valid == '0))
        else $error("outputs not idle after reset");

    // one output owns the payload bus at a time
    payload_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(m_payload_valid))
        else $error("more than one payload valid bit set");

    header_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(m_hdr_valid))
        else $error("more than one header valid bit set");

    // stalled beat keeps output, data and last
    payload_stable: assert property (@(posedge clk) disable iff (rst)
        (m_payload_valid != '0 && (m_payload_valid & m_payload_ready) == '0)
        |=> ($stable(m_payload_valid) && $stable(m_payload_data) && $stable(m_payload_last)))
        else $error("payload changed while stalled");

    header_held: assert property (@(posedge clk) disable iff (rst)
        ((m_hdr_valid & ~m_hdr_ready) != '0) |=> (m_hdr_valid == $past(m_hdr_valid)))
        else $error("header valid dropped before ready");

    // no new header while one is still pending
    header_refused: assert property (@(posedge clk) disable iff (rst)
        s_hdr_ready |-> (m_hdr_valid == '0))
        else $error("header ready high with a header pending");

endmodule

bind udp_demux udp_demux_assertions checks (
    .clk             (clk),
    .rst             (rst),
    .s_hdr_ready     (s_hdr_ready),
    .s_payload_ready (s_payload_ready),
    .m_hdr_valid     (m_hdr_valid),
    .m_hdr_ready     (m_hdr_ready),
    .m_payload_data  (m_payload_data),
    .m_payload_last  (m_payload_last),
    .m_payload_valid (m_payload_valid),
    .m_payload_ready (m_payload_ready)
);

//--- dv/udp_demux_tb.sv
/*
 * Testbench for the UDP frame demultiplexer: LFSR-driven frames with random
 * drops and output back-pressure, then directed drop, enable and ordering cases.
 */
module udp_demux_tb
    import udp_demux_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 300;
    localparam int RANDOM_FRAMES  = 60;

    logic          clk;
    logic          rst;
    logic          enable;
    logic          drop;
    port_sel_t     select;
    logic          s_hdr_valid;
    logic          s_hdr_ready;
    ip_addr_t      s_ip_source_ip;
    ip_addr_t      s_ip_dest_ip;
    udp_port_t     s_udp_source_port;
    udp_port_t     s_udp_dest_port;
    udp_length_t   s_udp_length;
    payload_data_t s_payload_data;
    logic          s_payload_last;
    logic          s_payload_valid;
    logic          s_payload_ready;
    port_mask_t    m_hdr_valid;
    port_mask_t    m_hdr_ready;
    ip_addr_t      m_ip_source_ip;
    ip_addr_t      m_ip_dest_ip;
    udp_port_t     m_udp_source_port;
    udp_port_t     m_udp_dest_port;
    udp_length_t   m_udp_length;
    payload_data_t m_payload_data;
    logic          m_payload_last;
    port_mask_t    m_payload_valid;
    port_mask_t    m_payload_ready;

    // stimulus and back-pressure use separate LFSR states
    logic [15:0]   stim_seed;
    logic [15:0]   ready_seed;
    logic [31:0]   ready_bits;
    port_mask_t    hdr_ready_rand;
    logic          hdr_hold;

    // expected {last, data} per output in send order
    logic [8:0]    exp_beats [OUT_COUNT][$];
    logic [8:0]    mon_beat;
    int            mon_idx;
    int            check_count;
    int            error_count;
    int            timeout_count;
    int            frame_idx;
    int            drain_wait;

    udp_demux uut (.*);

    // hdr_hold keeps every header pending for the ordering case
    assign m_hdr_ready = hdr_hold ? '0 : hdr_ready_rand;

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int count,
                             output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            state = lfsr_step(state);
            value = {value[30:0], state[0]};
        end
    endtask

    // output index a frame should reach, -1 when it is discarded
    function automatic int expected_port(input logic drop_flag, input port_sel_t sel);
        if (drop_flag) begin
            return -1;
        end
        return int'(sel);
    endfunction

    function automatic int beats_pending();
        int i;
        int total;
        total = 0;
        for (i = 0; i < OUT_COUNT; i++) begin
            total += exp_beats[i].size();
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at time %0t", name, got, exp, $time);
        end
    endtask

    // returns a small delay after the edge on which the input transfer happens
    task automatic wait_input_ready(input bit is_hdr);
        int   waited;
        logic seen_ready;
        waited = 0;
        @(negedge clk);
        seen_ready = is_hdr ? s_hdr_ready : s_payload_ready;
        while (!seen_ready && timeout_count == 0) begin
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                timeout_count++;
                $display("%s ready did not rise within %0d cycles",
                         is_hdr ? "header" : "payload", TIMEOUT_CYCLES);
            end else begin
                @(negedge clk);
                seen_ready = is_hdr ? s_hdr_ready : s_payload_ready;
            end
        end
        @(posedge clk);
        #1;
    endtask

    // drop_mode 0 random, 1 forced drop, 2 forced route
    task automatic run_frame(input int drop_mode, input int stall, input bit use_enable,
                             input bit hold_hdr);
        logic [31:0] r;
        logic        frame_drop;
        port_sel_t   frame_sel;
        int          port;
        int          len;
        int          b;
        int          k;
        draw_bits(stim_seed, 2, r);
        case (drop_mode)
            1: frame_drop = 1'b1;
            2: frame_drop = 1'b0;
            default: frame_drop = (r[1:0] == 2'd0);
        endcase
        draw_bits(stim_seed, SEL_WIDTH, r);
        frame_sel = port_sel_t'(r);
        draw_bits(stim_seed, 3, r);
        len  = int'(r[2:0]) + 1;
        port = expected_port(frame_drop, frame_sel);

        draw_bits(stim_seed, 32, r);
        s_ip_source_ip = r;
        draw_bits(stim_seed, 32, r);
        s_ip_dest_ip = r;
        draw_bits(stim_seed, 16, r);
        s_udp_source_port = r[15:0];
        draw_bits(stim_seed, 16, r);
        s_udp_dest_port = r[15:0];
        s_udp_length = udp_length_t'(len + 8);
        select       = frame_sel;
        drop         = frame_drop;
        s_hdr_valid  = 1'b1;
        if (use_enable) begin
            enable = 1'b0;
        end
        // header must be refused while enable is low or a header is pending
        for (k = 0; k < stall; k++) begin
            @(negedge clk);
            check_value("s_hdr_ready", 32'(s_hdr_ready), 32'd0);
        end
        if (stall > 0) begin
            @(posedge clk);
            #1;
            enable   = 1'b1;
            hdr_hold = 1'b0;
        end
        wait_input_ready(1'b1);
        s_hdr_valid = 1'b0;
        if (hold_hdr) begin
            hdr_hold = 1'b1;
        end

        @(negedge clk);
        check_value("m_hdr_valid", 32'(m_hdr_valid), (port < 0) ? 32'd0 : (32'd1 << port));
        // no further header while this frame is open, dropped or not
        check_value("s_hdr_ready", 32'(s_hdr_ready), 32'd0);
        if (port >= 0) begin
            check_value("m_ip_source_ip", m_ip_source_ip, s_ip_source_ip);
            check_value("m_ip_dest_ip", m_ip_dest_ip, s_ip_dest_ip);
            check_value("m_udp_source_port", 32'(m_udp_source_port), 32'(s_udp_source_port));
            check_value("m_udp_dest_port", 32'(m_udp_dest_port), 32'(s_udp_dest_port));
            check_value("m_udp_length", 32'(m_udp_length), 32'(s_udp_length));
        end
        @(posedge clk);
        #1;

        for (b = 0; b < len; b++) begin
            draw_bits(stim_seed, 2, r);
            if (r[1:0] == 2'd0) begin
                // idle cycle between beats
                @(posedge clk);
                #1;
            end
            draw_bits(stim_seed, 8, r);
            s_payload_data  = payload_data_t'(r);
            s_payload_last  = (b == len - 1);
            s_payload_valid = 1'b1;
            if (port >= 0) begin
                exp_beats[port].push_back({s_payload_last, s_payload_data});
            end
            if (use_enable && b == 0) begin
                enable = 1'b0;
                for (k = 0; k < stall; k++) begin
                    @(negedge clk);
                    check_value("s_payload_ready", 32'(s_payload_ready), 32'd0);
                end
                @(posedge clk);
                #1;
                enable = 1'b1;
            end
            wait_input_ready(1'b0);
            s_payload_valid = 1'b0;
        end
    endtask

    // random per-output back-pressure
    initial begin
        ready_seed      = 16'd17;
        m_payload_ready = '0;
        hdr_ready_rand  = '0;
        forever begin
            @(posedge clk);
            #1;
            draw_bits(ready_seed, OUT_COUNT, ready_bits);
            m_payload_ready = port_mask_t'(ready_bits);
            draw_bits(ready_seed, OUT_COUNT, ready_bits);
            hdr_ready_rand = port_mask_t'(ready_bits);
        end
    end

    // output monitor compares every payload transfer with its queue
    always @(negedge clk) begin
        if (!rst) begin
            for (mon_idx = 0; mon_idx < OUT_COUNT; mon_idx++) begin
                if (m_payload_valid[mon_idx] && m_payload_ready[mon_idx]) begin
                    if (exp_beats[mon_idx].size() == 0) begin
                        error_count++;
                        $display("payload beat 0x%0h arrived on output %0d with none expected",
                                 m_payload_data, mon_idx);
                    end else begin
                        mon_beat = exp_beats[mon_idx].pop_front();
                        check_value("m_payload_data", 32'(m_payload_data), 32'(mon_beat[7:0]));
                        check_value("m_payload_last", 32'(m_payload_last), 32'(mon_beat[8]));
                    end
                end
            end
        end
    end

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        enable            = 1'b1;
        drop              = 1'b0;
        select            = '0;
        s_hdr_valid       = 1'b0;
        s_ip_source_ip    = '0;
        s_ip_dest_ip      = '0;
        s_udp_source_port = '0;
        s_udp_dest_port   = '0;
        s_udp_length      = '0;
        s_payload_data    = '0;
        s_payload_last    = 1'b0;
        s_payload_valid   = 1'b0;
        hdr_hold          = 1'b0;
        stim_seed         = 16'd17;
        check_count       = 0;
        error_count       = 0;
        timeout_count     = 0;

        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value("s_hdr_ready", 32'(s_hdr_ready), 32'd0);
        check_value("s_payload_ready", 32'(s_payload_ready), 32'd0);
        check_value("m_hdr_valid", 32'(m_hdr_valid), 32'd0);
        check_value("m_payload_valid", 32'(m_payload_valid), 32'd0);
        @(posedge clk);
        #1;
        rst = 1'b0;
        // header ready comes up one cycle after reset
        @(negedge clk);
        check_value("s_hdr_ready", 32'(s_hdr_ready), 32'd0);
        @(negedge clk);
        check_value("s_hdr_ready", 32'(s_hdr_ready), 32'd1);
        @(posedge clk);
        #1;

        for (frame_idx = 0; frame_idx < RANDOM_FRAMES; frame_idx++) begin
            run_frame(0, 0, 1'b0, 1'b0);
        end
        // dropped frame followed by a routed one
        run_frame(1, 0, 1'b0, 1'b0);
        run_frame(2, 0, 1'b0, 1'b0);
        // enable low around the header and the first beat
        run_frame(2, 6, 1'b1, 1'b0);
        // header left pending so the next header has to wait
        run_frame(2, 0, 1'b0, 1'b1);
        run_frame(2, 5, 1'b0, 1'b0);

        drain_wait = 0;
        @(negedge clk);
        while ((beats_pending() != 0 || m_hdr_valid != '0) && timeout_count == 0) begin
            drain_wait++;
            if (drain_wait >= TIMEOUT_CYCLES) begin
                timeout_count++;
                $display("outputs did not drain within %0d cycles, %0d beats missing",
                         TIMEOUT_CYCLES, beats_pending());
            end else begin
                @(negedge clk);
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/udp_demux_pkg.sv
source/frame_select_ctrl.sv
source/payload_skid_buffer.sv
source/udp_demux.sv
dv/udp_demux_assertions.sv
dv/udp_demux_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the UDP demux testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module udp_demux_tb -f vlog.f \
    > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vudp_demux_tb > sim.log 2>&1 \
    || echo "simulator exited with an error status"

cat sim.log \
    && grep -qx "Testbench passed" sim.log \
    || { echo "pass message not found in sim.log"; exit 1; }

echo "simulation finished without errors"
